//--- Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - csr_pkg.sv
      - csr_time_base.sv
      - csr_regfile.sv
      - csr_exec_stage.sv
      - csr_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - csr_checker.sv
      - csr_tb.sv

//--- build.f
+incdir+.
csr_pkg.sv
csr_time_base.sv
csr_regfile.sv
csr_exec_stage.sv
csr_unit.sv
tb_clock_gen.sv
csr_checker.sv
csr_tb.sv

//--- csr_checker.sv
`include "csr_defs.svh"

module csr_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 flush,
    input csr_pkg::csr_req_t    req,
    input csr_pkg::csr_rsp_t    rsp,
    input logic [`CSR_XLEN-1:0] trap_vector
);
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    localparam int MODE_VALUE = 0;
    localparam int MODE_BASE  = 1;
    localparam int MODE_STEP  = 2;

    // One expected response per issued request
    typedef struct {
        int                   mode;
        csr_cmd_t             cmd;
        logic [`CSR_XLEN-1:0] data;
        logic [`CSR_XLEN-1:0] tvec;
    } exp_t;

    exp_t                 exp_q[$];
    int                   ready;
    int                   checks;
    int                   errors;
    int                   accepted;
    logic [`CSR_XLEN-1:0] base;

    initial begin
        ready    = 0;
        checks   = 0;
        errors   = 0;
        accepted = 0;
        base     = '0;
    end

    task automatic push(input int mode, input csr_cmd_t cmd,
                        input logic [`CSR_XLEN-1:0] data,
                        input logic [`CSR_XLEN-1:0] tvec);
        exp_t e;
        e.mode = mode;
        e.cmd  = cmd;
        e.data = data;
        e.tvec = tvec;
        exp_q.push_back(e);
    endtask

    // Exact rdata
    task automatic expect_value(input csr_cmd_t cmd, input logic [`CSR_XLEN-1:0] data,
                                input logic [`CSR_XLEN-1:0] tvec);
        push(MODE_VALUE, cmd, data, tvec);
    endtask

    // Counter read that only records the value
    task automatic expect_counter_base(input csr_cmd_t cmd, input logic [`CSR_XLEN-1:0] tvec);
        push(MODE_BASE, cmd, '0, tvec);
    endtask

    // Counter read that must be base plus step
    task automatic expect_counter_step(input csr_cmd_t cmd, input logic [`CSR_XLEN-1:0] step,
                                       input logic [`CSR_XLEN-1:0] tvec);
        push(MODE_STEP, cmd, step, tvec);
    endtask

    function automatic int outstanding();
        return exp_q.size();
    endfunction

    task automatic compare(input string name, input logic [`CSR_XLEN-1:0] got,
                           input logic [`CSR_XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Entries queued by now were sampled at this edge
    always @(posedge clk) begin
        ready = exp_q.size();
        if (rst_n && !flush && req.cmd != CSR_X) begin
            accepted++;
        end
    end

    // Mid-cycle, response and trap vector are settled
    always @(negedge clk) begin : check_rsp
        exp_t e;
        if (!rst_n) begin
            compare("rsp.cmd", 32'(rsp.cmd), 32'(CSR_X));
            compare("rsp.rdata", rsp.rdata, '0);
            compare("trap_vector", trap_vector, '0);
        end else if (ready > 0) begin
            e = exp_q.pop_front();
            ready--;
            compare("rsp.cmd", 32'(rsp.cmd), 32'(e.cmd));
            compare("trap_vector", trap_vector, e.tvec);
            case (e.mode)
                MODE_VALUE: compare("rsp.rdata", rsp.rdata, e.data);
                MODE_BASE:  base = rsp.rdata;
                default:    compare("rsp.rdata step", rsp.rdata - base, e.data);
            endcase
        end
    end

endmodule

//--- csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Width of every CSR and of the datapath
`define CSR_XLEN 32

// Core clock in MHz
// Also the number of clocks per microsecond tick of the time counter
`define CSR_TICK_DIV_DEFAULT 27

`endif

//--- csr_exec_stage.sv
`include "csr_defs.svh"

module csr_exec_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  csr_pkg::csr_req_t    req,
    input  logic [`CSR_XLEN-1:0] rdata,
    output logic [11:0]          raddr,
    output csr_pkg::csr_wr_t     wr,
    output csr_pkg::csr_cmd_t    rsp_cmd
);
    import csr_pkg::*;

    csr_cmd_t             cmd_in;
    csr_cmd_t             s_cmd;
    logic [11:0]          s_addr;
    logic [`CSR_XLEN-1:0] s_op1;

    // Read-modify-write value from the old register contents
    function automatic logic [`CSR_XLEN-1:0] wdata_calc(
        input csr_cmd_t             cmd,
        input logic [`CSR_XLEN-1:0] op1,
        input logic [`CSR_XLEN-1:0] old
    );
        case (cmd)
            CSR_W:     return op1;
            CSR_S:     return old | op1;
            CSR_C:     return old & ~op1;
            CSR_ECALL: return ECALL_CAUSE;
            default:   return '0;
        endcase
    endfunction

    // Flush from write-back kills the command in issue
    assign cmd_in = flush ? CSR_X : req.cmd;

    // Squashed reads go to address 0 which reads as zero
    // ecall reads the old cause
    always_comb begin
        if (flush) begin
            raddr = '0;
        end else if (req.cmd == CSR_ECALL) begin
            raddr = CSR_ADDR_MCAUSE;
        end else begin
            raddr = req.imm;
        end
    end

    // Command, target and operand held for the write cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_cmd  <= CSR_X;
            s_addr <= '0;
            s_op1  <= '0;
        end else begin
            s_cmd  <= cmd_in;
            s_addr <= raddr;
            s_op1  <= req.op1;
        end
    end

    // In the second cycle rdata is the old value
    assign wr.en   = (s_cmd != CSR_X);
    assign wr.addr = s_addr;
    assign wr.data = wdata_calc(s_cmd, s_op1, rdata);

    // Accepted command one cycle late
    assign rsp_cmd = s_cmd;

endmodule

//--- csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

    // CSR command from the execute stage
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4
    } csr_cmd_t;

    // Counters and timers, user-level read-only view
    localparam logic [11:0] CSR_ADDR_CYCLE    = 12'hc00;
    localparam logic [11:0] CSR_ADDR_TIME     = 12'hc01;
    localparam logic [11:0] CSR_ADDR_CYCLEH   = 12'hc80;
    localparam logic [11:0] CSR_ADDR_TIMEH    = 12'hc81;

    // Machine trap setup
    localparam logic [11:0] CSR_ADDR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_ADDR_MEDELEG  = 12'h302;
    localparam logic [11:0] CSR_ADDR_MIDELEG  = 12'h303;
    localparam logic [11:0] CSR_ADDR_MIE      = 12'h304;
    localparam logic [11:0] CSR_ADDR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_ADDR_MSTATUSH = 12'h310;

    // Machine trap handling
    localparam logic [11:0] CSR_ADDR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_ADDR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_ADDR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_ADDR_MTVAL    = 12'h343;
    localparam logic [11:0] CSR_ADDR_MIP      = 12'h344;

    // Request from execute, imm carries the CSR address
    typedef struct packed {
        csr_cmd_t             cmd;
        logic [`CSR_XLEN-1:0] op1;
        logic [11:0]          imm;
    } csr_req_t;

    // Response, one cycle after issue
    typedef struct packed {
        csr_cmd_t             cmd;
        logic [`CSR_XLEN-1:0] rdata;
    } csr_rsp_t;

    // Register file write port
    typedef struct packed {
        logic                 en;
        logic [11:0]          addr;
        logic [`CSR_XLEN-1:0] data;
    } csr_wr_t;

    // mstatus fields: SD, TSR..SPIE as one run (bits 22 to 5), MIE, SIE
    localparam logic [`CSR_XLEN-1:0] MSTATUS_WMASK  = 32'h807f_ffea;
    // mstatush: MBE and SBE only
    localparam logic [`CSR_XLEN-1:0] MSTATUSH_WMASK = 32'h0000_0030;

    // Environment call from M-mode
    localparam logic [`CSR_XLEN-1:0] ECALL_CAUSE = 32'd11;

endpackage

//--- csr_regfile.sv
`include "csr_defs.svh"

module csr_regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [11:0]          raddr,
    input  csr_pkg::csr_wr_t     wr,
    input  logic [63:0]          cycle,
    input  logic [63:0]          time_us,
    output logic [`CSR_XLEN-1:0] rdata,
    output logic [`CSR_XLEN-1:0] mtvec
);
    import csr_pkg::*;

    // Machine registers, mtvec is the output port itself
    logic [`CSR_XLEN-1:0] mstatus;
    logic [`CSR_XLEN-1:0] mstatush;
    logic [`CSR_XLEN-1:0] medeleg;
    logic [`CSR_XLEN-1:0] mideleg;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] mip;

    logic [`CSR_XLEN-1:0] rd_mux;
    logic [`CSR_XLEN-1:0] wr_mask;
    logic [`CSR_XLEN-1:0] wr_value;
    logic                 fwd_hit;

    // Stored bits per address, zero for anything not writable
    function automatic logic [`CSR_XLEN-1:0] wmask(input logic [11:0] addr);
        case (addr)
            CSR_ADDR_MSTATUS:  return MSTATUS_WMASK;
            CSR_ADDR_MSTATUSH: return MSTATUSH_WMASK;
            CSR_ADDR_MEDELEG,
            CSR_ADDR_MIDELEG,
            CSR_ADDR_MIE,
            CSR_ADDR_MTVEC,
            CSR_ADDR_MSCRATCH,
            CSR_ADDR_MEPC,
            CSR_ADDR_MCAUSE,
            CSR_ADDR_MTVAL,
            CSR_ADDR_MIP:      return '1;
            default:           return '0;
        endcase
    endfunction

    assign wr_mask  = wmask(wr.addr);
    assign wr_value = wr.data & wr_mask;

    // Write in flight to the address being read
    // Counters and unknown addresses never hit
    assign fwd_hit = wr.en && (wr.addr == raddr) && (|wr_mask);

    // Read decode
    always_comb begin
        case (raddr)
            CSR_ADDR_CYCLE:    rd_mux = cycle[`CSR_XLEN-1:0];
            CSR_ADDR_TIME:     rd_mux = time_us[`CSR_XLEN-1:0];
            CSR_ADDR_CYCLEH:   rd_mux = cycle[63:`CSR_XLEN];
            CSR_ADDR_TIMEH:    rd_mux = time_us[63:`CSR_XLEN];
            CSR_ADDR_MSTATUS:  rd_mux = mstatus;
            CSR_ADDR_MSTATUSH: rd_mux = mstatush;
            CSR_ADDR_MEDELEG:  rd_mux = medeleg;
            CSR_ADDR_MIDELEG:  rd_mux = mideleg;
            CSR_ADDR_MIE:      rd_mux = mie;
            CSR_ADDR_MTVEC:    rd_mux = mtvec;
            CSR_ADDR_MSCRATCH: rd_mux = mscratch;
            CSR_ADDR_MEPC:     rd_mux = mepc;
            CSR_ADDR_MCAUSE:   rd_mux = mcause;
            CSR_ADDR_MTVAL:    rd_mux = mtval;
            CSR_ADDR_MIP:      rd_mux = mip;
            // misa, info regs, mtinst etc.
            default:           rd_mux = '0;
        endcase
    end

    // Registered read port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else begin
            rdata <= fwd_hit ? wr_value : rd_mux;
        end
    end

    // Masked write port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus  <= '0;
            mstatush <= '0;
            medeleg  <= '0;
            mideleg  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mip      <= '0;
        end else if (wr.en) begin
            case (wr.addr)
                CSR_ADDR_MSTATUS:  mstatus  <= wr_value;
                CSR_ADDR_MSTATUSH: mstatush <= wr_value;
                CSR_ADDR_MEDELEG:  medeleg  <= wr_value;
                CSR_ADDR_MIDELEG:  mideleg  <= wr_value;
                CSR_ADDR_MIE:      mie      <= wr_value;
                CSR_ADDR_MTVEC:    mtvec    <= wr_value;
                CSR_ADDR_MSCRATCH: mscratch <= wr_value;
                CSR_ADDR_MEPC:     mepc     <= wr_value;
                CSR_ADDR_MCAUSE:   mcause   <= wr_value;
                CSR_ADDR_MTVAL:    mtval    <= wr_value;
                CSR_ADDR_MIP:      mip      <= wr_value;
                // Read-only or unknown, dropped
                default: ;
            endcase
        end
    end

endmodule

//--- csr_tb.sv
`include "csr_defs.svh"

module csr_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int TICK_DIV   = `CSR_TICK_DIV_DEFAULT;
    localparam int RAND_CMDS  = 300;
    // Directed part issues fewer than 200 requests
    localparam int N_CMDS     = RAND_CMDS + 200;
    localparam int KIND_VALUE = 0;
    localparam int KIND_BASE  = 1;
    localparam int KIND_STEP  = 2;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    csr_req_t             req;
    csr_rsp_t             rsp;
    logic [`CSR_XLEN-1:0] trap_vector;

    // Reference register state with one word per CSR address
    logic [`CSR_XLEN-1:0] model [4096] = '{default: '0};
    int                   n_cmds = 0;

    logic [11:0] writable [11] = '{
        CSR_ADDR_MSTATUS, CSR_ADDR_MSTATUSH, CSR_ADDR_MEDELEG, CSR_ADDR_MIDELEG,
        CSR_ADDR_MIE, CSR_ADDR_MTVEC, CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC,
        CSR_ADDR_MCAUSE, CSR_ADDR_MTVAL, CSR_ADDR_MIP
    };
    // Small set so random traffic often hits the same register
    logic [11:0] hot [7] = '{
        CSR_ADDR_MSCRATCH, CSR_ADDR_MSTATUS, CSR_ADDR_MSTATUSH, CSR_ADDR_MTVEC,
        CSR_ADDR_MCAUSE, CSR_ADDR_MIE, 12'h301
    };

    tb_clock_gen #(.period(CLK_PERIOD), .reset_cycles(2)) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    csr_unit #(.tick_div(TICK_DIV)) csr_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .req         (req),
        .rsp         (rsp),
        .trap_vector (trap_vector)
    );

    csr_checker chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .req         (req),
        .rsp         (rsp),
        .trap_vector (trap_vector)
    );

    // Implemented mstatus fields by bit position
    function automatic logic [`CSR_XLEN-1:0] mstatus_fields();
        logic [`CSR_XLEN-1:0] m;
        m = '0;
        // SD
        m[31] = 1'b1;
        // TSR, TW, TVM, MXR, SUM, MPRV
        m[22:17] = '1;
        // XS, FS, MPP, VS
        m[16:9] = '1;
        // SPP, MPIE, UBE, SPIE
        m[8:5] = '1;
        // MIE and SIE
        m[3] = 1'b1;
        m[1] = 1'b1;
        return m;
    endfunction

    // Bits kept by a write to each address
    function automatic logic [`CSR_XLEN-1:0] stored_bits(input logic [11:0] a);
        logic [`CSR_XLEN-1:0] bits;
        bits = '0;
        if (a == CSR_ADDR_MSTATUS) begin
            bits = mstatus_fields();
        end else if (a == CSR_ADDR_MSTATUSH) begin
            // MBE and SBE
            bits[5:4] = 2'b11;
        end else begin
            foreach (writable[i]) begin
                if (writable[i] == a) begin
                    bits = '1;
                end
            end
        end
        return bits;
    endfunction

    // Expected response before the write is applied to the model
    function automatic csr_rsp_t ref_apply(input csr_req_t r, input logic fl);
        csr_rsp_t             e;
        logic [11:0]          a;
        logic [`CSR_XLEN-1:0] nv;
        e.cmd   = CSR_X;
        e.rdata = '0;
        if (fl) return e;
        a       = (r.cmd == CSR_ECALL) ? CSR_ADDR_MCAUSE : r.imm;
        e.cmd   = r.cmd;
        e.rdata = model[a];
        case (r.cmd)
            CSR_W:     nv = r.op1;
            CSR_S:     nv = model[a] | r.op1;
            CSR_C:     nv = model[a] & ~r.op1;
            CSR_ECALL: nv = 32'd11;
            default:   return e;
        endcase
        model[a] = nv & stored_bits(a);
        return e;
    endfunction

    task automatic issue(input csr_cmd_t cmd, input logic [`CSR_XLEN-1:0] op1,
                         input logic [11:0] imm, input logic fl, input int kind,
                         input logic [`CSR_XLEN-1:0] step);
        csr_req_t             r;
        csr_rsp_t             e;
        logic [`CSR_XLEN-1:0] tvec;
        @(posedge clk);
        #5;
        r.cmd = cmd;
        r.op1 = op1;
        r.imm = imm;
        // trap_vector at check time still shows mtvec before this write
        tvec  = model[CSR_ADDR_MTVEC];
        e     = ref_apply(r, fl);
        req   = r;
        flush = fl;
        n_cmds++;
        case (kind)
            KIND_BASE: chk_i.expect_counter_base(e.cmd, tvec);
            KIND_STEP: chk_i.expect_counter_step(e.cmd, step, tvec);
            default:   chk_i.expect_value(e.cmd, e.rdata, tvec);
        endcase
    endtask

    task automatic idle();
        issue(CSR_X, '0, '0, 1'b0, KIND_VALUE, '0);
    endtask

    // Read as csrrs with x0 so no bits change
    task automatic read_csr(input logic [11:0] a, input int kind, input int step);
        issue(CSR_S, '0, a, 1'b0, kind, step);
    endtask

    initial begin : stimulus
        logic [11:0] a;
        csr_cmd_t    c;
        int          seed;
        seed  = $urandom(96);
        req   = '0;
        flush = 1'b0;
        @(posedge rst_n);
        repeat (4) idle();
        // Write, set, clear and read back on every writable register
        foreach (writable[i]) begin
            a = writable[i];
            issue(CSR_W, {a, 4'h5, ~a, 4'ha}, a, 1'b0, KIND_VALUE, '0);
            issue(CSR_S, 32'h0f0f_0f0f, a, 1'b0, KIND_VALUE, '0);
            issue(CSR_C, 32'h00ff_00ff, a, 1'b0, KIND_VALUE, '0);
            read_csr(a, KIND_VALUE, 0);
        end
        // Read-only and unimplemented addresses keep reading zero
        issue(CSR_W, 32'hffff_ffff, CSR_ADDR_CYCLEH, 1'b0, KIND_VALUE, '0);
        read_csr(CSR_ADDR_CYCLEH, KIND_VALUE, 0);
        issue(CSR_W, 32'h4000_1105, 12'h301, 1'b0, KIND_VALUE, '0);
        read_csr(12'h301, KIND_VALUE, 0);
        issue(CSR_W, 32'h1234_5678, 12'hf11, 1'b0, KIND_VALUE, '0);
        read_csr(12'hf11, KIND_VALUE, 0);
        // Ecall returns the old cause and mcause then holds 11
        issue(CSR_W, 32'h0000_1234, CSR_ADDR_MCAUSE, 1'b0, KIND_VALUE, '0);
        issue(CSR_ECALL, 32'hdead_beef, 12'h000, 1'b0, KIND_VALUE, '0);
        read_csr(CSR_ADDR_MCAUSE, KIND_VALUE, 0);
        // Flushed write and flushed ecall must not land
        issue(CSR_W, 32'hcafe_0001, CSR_ADDR_MSCRATCH, 1'b0, KIND_VALUE, '0);
        issue(CSR_W, 32'hdead_0002, CSR_ADDR_MSCRATCH, 1'b1, KIND_VALUE, '0);
        issue(CSR_W, 32'h0000_0003, CSR_ADDR_MCAUSE, 1'b0, KIND_VALUE, '0);
        issue(CSR_ECALL, '0, '0, 1'b1, KIND_VALUE, '0);
        read_csr(CSR_ADDR_MSCRATCH, KIND_VALUE, 0);
        read_csr(CSR_ADDR_MCAUSE, KIND_VALUE, 0);
        // New trap vector seen by the checks that follow
        issue(CSR_W, 32'h8000_0100, CSR_ADDR_MTVEC, 1'b0, KIND_VALUE, '0);
        repeat (2) idle();
        // Cycle reads 7 apart
        read_csr(CSR_ADDR_CYCLE, KIND_BASE, 0);
        repeat (6) idle();
        read_csr(CSR_ADDR_CYCLE, KIND_STEP, 7);
        // Time reads three ticks apart
        read_csr(CSR_ADDR_TIME, KIND_BASE, 0);
        repeat (3 * TICK_DIV - 1) idle();
        read_csr(CSR_ADDR_TIME, KIND_STEP, 3);
        read_csr(CSR_ADDR_CYCLEH, KIND_VALUE, 0);
        // Random back-to-back traffic with occasional flush
        for (int i = 0; i < RAND_CMDS; i++) begin
            a = hot[$urandom_range(6)];
            case ($urandom_range(6))
                0, 1:    c = CSR_W;
                2, 3:    c = CSR_S;
                4, 5:    c = CSR_C;
                default: c = CSR_ECALL;
            endcase
            issue(c, $urandom(), a, ($urandom_range(15) == 0), KIND_VALUE, '0);
        end
        idle();
        // Let the checker drain the last responses
        while (chk_i.outstanding() != 0) @(negedge clk);
        #1;
        $display("Checks %0d, errors %0d, requests issued %0d, commands accepted %0d",
                 chk_i.checks, chk_i.errors, n_cmds, chk_i.accepted);
        if (chk_i.errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the number of requests
    initial begin : watchdog
        #((200 * N_CMDS + 1000) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the watchdog limit");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- csr_time_base.sv
`include "csr_defs.svh"

module csr_time_base #(
    parameter int tick_div = `CSR_TICK_DIV_DEFAULT
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic [63:0] cycle,
    output logic [63:0] time_us
);
    import csr_pkg::*;

    // Prescaler width, at least one bit for tick_div of 1
    localparam int presc_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [presc_w-1:0] presc;
    logic               tick;

    // Last clock of each microsecond
    assign tick = (presc == presc_w'(tick_div - 1));

    // Free-running, counts every edge after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // Prescaler wraps on tick and advances time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc   <= '0;
            time_us <= '0;
        end else if (tick) begin
            presc   <= '0;
            time_us <= time_us + 64'd1;
        end else begin
            presc   <= presc + presc_w'(1);
        end
    end

endmodule

//--- csr_unit.sv
`include "csr_defs.svh"

module csr_unit #(
    parameter int tick_div = `CSR_TICK_DIV_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  csr_pkg::csr_req_t    req,
    output csr_pkg::csr_rsp_t    rsp,
    output logic [`CSR_XLEN-1:0] trap_vector
);
    import csr_pkg::*;

    logic [11:0]          raddr;
    csr_wr_t              wr;
    csr_cmd_t             rsp_cmd;
    logic [`CSR_XLEN-1:0] rdata;
    logic [63:0]          cycle;
    logic [63:0]          time_us;

    // Issue and write-back control
    csr_exec_stage u_exec (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .req     (req),
        .rdata   (rdata),
        .raddr   (raddr),
        .wr      (wr),
        .rsp_cmd (rsp_cmd)
    );

    // Storage, mtvec straight out as the trap vector
    csr_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr   (raddr),
        .wr      (wr),
        .cycle   (cycle),
        .time_us (time_us),
        .rdata   (rdata),
        .mtvec   (trap_vector)
    );

    csr_time_base #(
        .tick_div (tick_div)
    ) u_time (
        .clk     (clk),
        .rst_n   (rst_n),
        .cycle   (cycle),
        .time_us (time_us)
    );

    // Both fields registered one cycle after issue
    assign rsp.cmd   = rsp_cmd;
    assign rsp.rdata = rdata;

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period       = 100,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // Free-running clock, low for the first half period
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Release just after an edge, same offset as the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #5;
        rst_n = 1'b1;
    end

endmodule
